// ==== files.f ====
verilog/mont_pkg.sv
verilog/wb_pkg.sv
verilog/operand_fetch.sv
verilog/mont_core.sv
verilog/result_store.sv
verilog/wb_arbiter.sv
verilog/mont_accel_top.sv
tb/mont_accel_checker.sv
tb/tb_mont_accel.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it; the pass line in the output decides
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/100ps -Wno-fatal -j 0 \
	--top-module tb_mont_accel -f files.f -o tb_mont_accel \
	&& ./obj_dir/tb_mont_accel | tee /dev/stderr | grep -x "sim passed" > /dev/null \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

// ==== tb/mont_accel_checker.sv ====
`default_nettype none

module mont_accel_checker
	import wb_pkg::*;
(
	input logic    clk,
	input logic    rst_n,
	input wb_m2s_t wb_o,
	input wb_s2m_t wb_i,
	input logic    done
);

	timeunit 1ns;
	timeprecision 100ps;

	stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
		wb_o.stb |-> wb_o.cyc)
		else $error("Wishbone stb high without cyc");

	// Master holds the whole request until the slave acks
	req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_o.stb && !wb_i.ack) |=> $stable(wb_o))
		else $error("Wishbone request changed before ack");

	done_single: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else $error("done high for two cycles in a row");

	idle_in_reset: assert property (@(posedge clk)
		!rst_n |-> !wb_o.cyc)  // No bus cycle while reset is held
		else $error("Wishbone cyc high during reset");

endmodule

bind mont_accel_top mont_accel_checker i_mont_accel_checker (
	.clk   (clk),
	.rst_n (rst_n),
	.wb_o  (wb_o),
	.wb_i  (wb_i),
	.done  (done)
);

`default_nettype wire

// ==== tb/mont_testdata.txt ====
// One vector per line: A B N expected, 128-bit hex values
// expected = A * B * 2^-128 mod N, N odd, A and B below N
10 0123456789abcdeffedcba9876543210 ffffffffffffffffffffffffffffffff 123456789abcdeffedcba98765432100
100000000 0123456789abcdeffedcba9876543210 ffffffffffffffffffffffffffffffff 89abcdeffedcba987654321001234567
10000000000000000 deadbeefcafebabe0000000000000001 ffffffffffffffffffffffffffffffff 1deadbeefcafebabe
fffffffffffffffffffffffffffffffe fffffffffffffffffffffffffffffffe ffffffffffffffffffffffffffffffff 1
fffffffffffffffffffffffffffffffe 0123456789abcdeffedcba9876543210 ffffffffffffffffffffffffffffffff fedcba98765432100123456789abcdef
0 0123456789abcdeffedcba9876543210 ffffffffffffffffffffffffffffffff 0
0123456789abcdeffedcba9876543210 0 ffffffffffffffffffffffffffffffff 0
1 deadbeefcafebabe0000000000000001 ffffffffffffffffffffffffffffffff deadbeefcafebabe0000000000000001
1 1 80000000000000000000000000000001 40000000000000000000000000000000
2 1 80000000000000000000000000000001 80000000000000000000000000000000
2 2 80000000000000000000000000000001 7fffffffffffffffffffffffffffffff
80000000000000000000000000000000 80000000000000000000000000000000 80000000000000000000000000000001 40000000000000000000000000000000
2 2 3 1
3 4 5 2
3 5 7 2
7 b f 2
10 10 11 1
c8 64 ff 6e
100 100 101 1
1234 5678 10001 fa3b

// ==== tb/tb_mont_accel.sv ====
`default_nettype none

module tb_mont_accel
	import mont_pkg::*, wb_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int WORDS          = 4;
	localparam int BITS           = WORDS * 32;
	localparam int NVEC           = 20;
	localparam int MEM_WORDS      = NVEC * 16;  // 64 bytes per vector
	localparam int RESET_CYCLES   = 8;
	localparam int TIMEOUT_CYCLES = NVEC * (2 * BITS + 1 + 40 * 12) + 2 * RESET_CYCLES;

	logic      clk;
	logic      rst_n;
	mont_cmd_t cmd;
	logic      cmd_valid;
	logic      cmd_ready;
	wb_m2s_t   wb_o;
	wb_s2m_t   wb_i;
	logic      done;

	logic [BITS-1:0] vec_mem [0:4*NVEC-1];  // A, B, N, expected for each vector
	logic [31:0]     mem [0:MEM_WORDS-1];
	int              pending [$];           // Accepted commands still waiting for done
	int              error_count;
	int              done_count;
	int              read_count;
	int              write_count;
	logic            busy;                  // Memory model is timing a transfer
	int              delay;

	mont_accel_top #(.WORDS(WORDS)) i_mont_accel_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.wb_o      (wb_o),
		.wb_i      (wb_i),
		.done      (done)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic compare_value(input string name, input logic [BITS-1:0] expected,
			input logic [BITS-1:0] actual);
		if (expected !== actual) begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_idle_outputs();
		compare_value("wb_o.cyc", 0, wb_o.cyc);
		compare_value("wb_o.stb", 0, wb_o.stb);
		compare_value("done", 0, done);
		compare_value("cmd_ready", 1, cmd_ready);
	endtask

	// Each vector takes 64 bytes with A at +0, B at +16, N at +32 and the result at +48
	function automatic mont_cmd_t make_cmd(int v);
		mont_cmd_t c;
		c.a_adr = addr_t'(v * 64);
		c.b_adr = addr_t'(v * 64 + 16);
		c.n_adr = addr_t'(v * 64 + 32);
		c.r_adr = addr_t'(v * 64 + 48);
		return c;
	endfunction

	function automatic logic [BITS-1:0] read_result(int v);
		logic [BITS-1:0] value;
		for (int j = 0; j < WORDS; j++)
			value[j*32 +: 32] = mem[v*16 + 12 + j];  // Word 0 is least significant
		return value;
	endfunction

	task automatic check_data();
		for (int v = 0; v < NVEC; v++) begin
			if (!vec_mem[4*v+2][0] || vec_mem[4*v] >= vec_mem[4*v+2]
					|| vec_mem[4*v+1] >= vec_mem[4*v+2]) begin
				$display("Error: vector %0d needs an odd N above both A and B", v);
				error_count++;
			end
		end
	endtask

	task automatic preload_memory();
		for (int w = 0; w < MEM_WORDS; w++)
			mem[w] = 32'hc0de_0000 ^ (w * 32'h9e37_79b1);
		for (int v = 0; v < NVEC; v++) begin
			for (int j = 0; j < WORDS; j++) begin
				mem[v*16 + j]     = vec_mem[4*v][j*32 +: 32];
				mem[v*16 + 4 + j] = vec_mem[4*v+1][j*32 +: 32];
				mem[v*16 + 8 + j] = vec_mem[4*v+2][j*32 +: 32];
			end
		end
	endtask

	// Completes the transfer on the bus now and raises ack for the next cycle
	task automatic respond();
		int unsigned word;
		int unsigned offset;
		word   = wb_o.adr >> 2;
		offset = wb_o.adr & 32'd63;
		wb_i.ack <= 1'b1;
		compare_value("wb_o.sel", 4'hf, wb_o.sel);
		if (wb_o.adr[1:0] != 2'b00 || word >= MEM_WORDS) begin
			$display("Error: transfer to address %h lies outside the memory model", wb_o.adr);
			error_count++;
		end else if (wb_o.we) begin
			if (offset < 48) begin
				$display("Error: write to address %h is outside every result region", wb_o.adr);
				error_count++;
			end
			mem[word] = wb_o.dat;
			write_count++;
		end else begin
			if (offset >= 48) begin
				$display("Error: read from address %h is outside every operand region", wb_o.adr);
				error_count++;
			end
			wb_i.dat <= mem[word];
			read_count++;
		end
	endtask

	always @(posedge clk) begin
		int unsigned wait_cycles;
		if (!rst_n) begin
			wb_i  <= '0;
			busy  <= 1'b0;
			delay <= 0;
		end else if (wb_i.ack) begin
			wb_i.ack <= 1'b0;  // Single cycle ack
			busy     <= 1'b0;
		end else if (wb_o.cyc && wb_o.stb) begin
			if (!busy) begin
				wait_cycles = $urandom % 4;
				busy <= 1'b1;
				if (wait_cycles == 0)
					respond();
				else
					delay <= wait_cycles;
			end else if (delay <= 1) begin
				respond();
			end else begin
				delay <= delay - 1;
			end
		end
	end

	// Results must land in command order
	always @(negedge clk) begin
		int v;
		if (rst_n && done) begin
			done_count++;
			if (pending.size() == 0) begin
				$display("Error: done pulsed with no command outstanding");
				error_count++;
			end else begin
				v = pending.pop_front();
				compare_value($sformatf("result[%0d]", v), vec_mem[4*v+3], read_result(v));
			end
		end
	end

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Error: run timed out after %0d cycles", TIMEOUT_CYCLES);
		$display("%0d errors, %0d of %0d commands done", error_count + 1, done_count, NVEC);
		$display("sim failed");
		$finish;
	end

	initial begin : main
		rst_n       <= 1'b0;
		cmd         <= '0;
		cmd_valid   <= 1'b0;
		wb_i        <= '0;
		error_count = 0;
		done_count  = 0;
		read_count  = 0;
		write_count = 0;
		void'($urandom(40777));
		$readmemh("tb/mont_testdata.txt", vec_mem);
		check_data();
		preload_memory();
		repeat (RESET_CYCLES / 2) @(posedge clk);
		@(negedge clk);
		check_idle_outputs();  // Inside reset
		repeat (RESET_CYCLES / 2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_idle_outputs();
		@(posedge clk);
		for (int v = 0; v < NVEC; v++) begin
			cmd       <= make_cmd(v);
			cmd_valid <= 1'b1;
			@(posedge clk);
			while (!cmd_ready)
				@(posedge clk);
			pending.push_back(v);  // Handshake on this edge
		end
		cmd_valid <= 1'b0;
		wait (done_count == NVEC);
		repeat (8) @(posedge clk);
		compare_value("done count", NVEC, done_count);
		compare_value("outstanding commands", 0, pending.size());
		compare_value("read count", 12 * NVEC, read_count);
		compare_value("write count", 4 * NVEC, write_count);
		for (int v = 0; v < NVEC; v++)
			compare_value($sformatf("stored result[%0d]", v), vec_mem[4*v+3], read_result(v));
		$display("%0d errors, %0d commands, %0d done pulses, %0d reads, %0d writes",
			error_count, NVEC, done_count, read_count, write_count);
		if (error_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/mont_accel_top.sv ====
`default_nettype none

module mont_accel_top
	import mont_pkg::*, wb_pkg::*;
#(
	parameter int WORDS = 4
) (
	input  logic      clk,
	input  logic      rst_n,
	input  mont_cmd_t cmd,
	input  logic      cmd_valid,
	output logic      cmd_ready,
	output wb_m2s_t   wb_o,
	input  wb_s2m_t   wb_i,
	output logic      done
);

	mont_operands_t ops;
	logic           ops_valid;
	logic           ops_ready;
	mont_result_t   res;
	logic           res_valid;
	logic           res_ready;

	wb_m2s_t        fetch_req;
	wb_s2m_t        fetch_rsp;
	wb_m2s_t        store_req;
	wb_s2m_t        store_rsp;

	operand_fetch #(.WORDS(WORDS)) i_operand_fetch (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.wb_o      (fetch_req),
		.wb_i      (fetch_rsp),
		.ops       (ops),
		.ops_valid (ops_valid),
		.ops_ready (ops_ready)
	);

	mont_core #(.WORDS(WORDS)) i_mont_core (
		.clk       (clk),
		.rst_n     (rst_n),
		.ops       (ops),
		.ops_valid (ops_valid),
		.ops_ready (ops_ready),
		.res       (res),
		.res_valid (res_valid),
		.res_ready (res_ready)
	);

	result_store #(.WORDS(WORDS)) i_result_store (
		.clk       (clk),
		.rst_n     (rst_n),
		.res       (res),
		.res_valid (res_valid),
		.res_ready (res_ready),
		.wb_o      (store_req),
		.wb_i      (store_rsp),
		.done      (done)
	);

	wb_arbiter i_wb_arbiter (
		.clk       (clk),
		.rst_n     (rst_n),
		.fetch_req (fetch_req),
		.fetch_rsp (fetch_rsp),
		.store_req (store_req),
		.store_rsp (store_rsp),
		.wb_o      (wb_o),
		.wb_i      (wb_i)
	);

endmodule

`default_nettype wire

// ==== verilog/mont_core.sv ====
`default_nettype none

module mont_core
	import mont_pkg::*;
#(
	parameter int WORDS = 4
) (
	input  logic           clk,
	input  logic           rst_n,
	input  mont_operands_t ops,
	input  logic           ops_valid,
	output logic           ops_ready,
	output mont_result_t   res,
	output logic           res_valid,
	input  logic           res_ready
);

	localparam int BITS  = WORDS * 32;
	localparam int CNT_W = $clog2(BITS);

	typedef enum logic [2:0] {idle, add_b, add_n, reduce, hold} state_t;

	state_t           state;
	logic [CNT_W-1:0] cnt;    // Multiplier bit number
	logic [BITS-1:0]  a_q;    // Shifts right once per bit
	logic [BITS+1:0]  b_q;
	logic [BITS+1:0]  n_q;
	logic [BITS+1:0]  m;      // Accumulator, stays below 2N
	addr_t            r_adr_q;

	logic [BITS+1:0]  adder_in;
	logic             carry;
	logic [BITS+2:0]  adder_out;
	logic [BITS+1:0]  sum;
	logic             geq;

	// One adder for every step
	// The extra low bit turns carry into the +1 of a two's complement subtract
	always_comb begin
		adder_in = b_q;
		carry    = 1'b0;
		case (state)
			add_n: adder_in = n_q;
			reduce: begin
				adder_in = ~n_q;  // M - N
				carry    = 1'b1;
			end
			default: ;
		endcase
	end

	assign adder_out = {m, 1'b1} + {adder_in, carry};
	assign sum       = adder_out[BITS+2:1];
	assign geq       = m[BITS+1] | ~adder_out[BITS+2];  // Sign of M - N

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			cnt   <= '0;
		end else begin
			case (state)
				idle: if (ops_valid) begin
					state <= add_b;
					cnt   <= '0;
				end
				add_b: state <= add_n;
				add_n: begin
					cnt   <= cnt + 1'b1;
					state <= (cnt == CNT_W'(BITS - 1)) ? reduce : add_b;
				end
				reduce: state <= hold;
				hold: if (res_ready)
					state <= idle;
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			idle: if (ops_valid) begin
				a_q     <= ops.a[BITS-1:0];
				b_q     <= {2'b00, ops.b[BITS-1:0]};
				n_q     <= {2'b00, ops.n[BITS-1:0]};
				r_adr_q <= ops.r_adr;
				m       <= '0;
			end
			add_b: begin
				if (a_q[0])
					m <= sum;        // M + B
				a_q <= a_q >> 1;
			end
			// Make M even with N, then halve
			add_n: m <= m[0] ? (sum >> 1) : (m >> 1);
			reduce: if (geq)
				m <= sum;            // Final subtraction
			default: ;
		endcase
	end

	assign ops_ready = (state == idle);
	assign res_valid = (state == hold);
	assign res       = '{m: mont_num_t'(m[BITS-1:0]), r_adr: r_adr_q};

endmodule

`default_nettype wire

// ==== verilog/mont_pkg.sv ====
`default_nettype none

package mont_pkg;

	// Largest operand the bundle structs can carry
	localparam int MAX_WORDS = 16;
	localparam int MAX_BITS  = MAX_WORDS * 32;

	typedef logic [31:0] word_t;          // One memory data word
	typedef logic [31:0] addr_t;          // Byte address
	typedef logic [MAX_BITS-1:0] mont_num_t;  // Operand or product, low BITS used

	// Fetch to core
	typedef struct packed {
		mont_num_t a;     // Multiplier
		mont_num_t b;     // Multiplicand
		mont_num_t n;     // Odd modulus
		addr_t     r_adr; // Where the product goes
	} mont_operands_t;

	// Core to store
	typedef struct packed {
		mont_num_t m;
		addr_t     r_adr;
	} mont_result_t;

endpackage

`default_nettype wire

// ==== verilog/operand_fetch.sv ====
`default_nettype none

module operand_fetch
	import mont_pkg::*, wb_pkg::*;
#(
	parameter int WORDS = 4
) (
	input  logic           clk,
	input  logic           rst_n,
	input  mont_cmd_t      cmd,
	input  logic           cmd_valid,
	output logic           cmd_ready,
	output wb_m2s_t        wb_o,
	input  wb_s2m_t        wb_i,
	output mont_operands_t ops,
	output logic           ops_valid,
	input  logic           ops_ready
);

	localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;

	typedef enum logic [1:0] {idle, read, hold} state_t;

	state_t           state;
	logic [1:0]       sel;   // Operand being read, 0 is B, 1 is N, 2 is A
	logic [IDX_W-1:0] idx;   // Word within the operand
	logic             last_word;
	addr_t            base;
	mont_cmd_t        cmd_q;
	mont_operands_t   ops_q;

	assign last_word = (idx == IDX_W'(WORDS - 1));

	always_comb begin
		case (sel)
			2'd0:    base = cmd_q.b_adr;
			2'd1:    base = cmd_q.n_adr;
			default: base = cmd_q.a_adr;
		endcase
	end

	// Reads only, one transfer per word
	always_comb begin
		wb_o     = '0;
		wb_o.cyc = (state == read);
		wb_o.stb = (state == read);
		wb_o.adr = base + (addr_t'(idx) << 2);
		wb_o.sel = 4'hf;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			sel   <= '0;
			idx   <= '0;
		end else begin
			case (state)
				idle: if (cmd_valid) begin
					state <= read;
					sel   <= '0;
					idx   <= '0;
				end
				read: if (wb_i.ack) begin
					if (last_word) begin
						idx <= '0;
						sel <= sel + 2'd1;
						if (sel == 2'd2)
							state <= hold;  // A was the last operand
					end else begin
						idx <= idx + 1'b1;
					end
				end
				hold: if (ops_ready)
					state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// Bundle register, each acked word goes to its slot
	always_ff @(posedge clk) begin
		if (state == idle && cmd_valid) begin
			cmd_q <= cmd;
			ops_q <= '{a: '0, b: '0, n: '0, r_adr: cmd.r_adr};
		end else if (state == read && wb_i.ack) begin
			case (sel)
				2'd0:    ops_q.b[idx*32 +: 32] <= wb_i.dat;
				2'd1:    ops_q.n[idx*32 +: 32] <= wb_i.dat;
				default: ops_q.a[idx*32 +: 32] <= wb_i.dat;
			endcase
		end
	end

	assign cmd_ready = (state == idle);
	assign ops_valid = (state == hold);
	assign ops       = ops_q;

endmodule

`default_nettype wire

// ==== verilog/result_store.sv ====
`default_nettype none

module result_store
	import mont_pkg::*, wb_pkg::*;
#(
	parameter int WORDS = 4
) (
	input  logic         clk,
	input  logic         rst_n,
	input  mont_result_t res,
	input  logic         res_valid,
	output logic         res_ready,
	output wb_m2s_t      wb_o,
	input  wb_s2m_t      wb_i,
	output logic         done
);

	localparam int BITS  = WORDS * 32;
	localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;

	typedef enum logic [1:0] {idle, write, finish} state_t;

	state_t           state;
	logic [IDX_W-1:0] idx;
	logic [BITS-1:0]  m_q;
	addr_t            r_adr_q;

	always_comb begin
		wb_o     = '0;
		wb_o.cyc = (state == write);
		wb_o.stb = (state == write);
		wb_o.we  = 1'b1;
		wb_o.adr = r_adr_q + (addr_t'(idx) << 2);
		wb_o.dat = word_t'(m_q[idx*32 +: 32]);  // Least significant word first
		wb_o.sel = 4'hf;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			idx   <= '0;
		end else begin
			case (state)
				idle: if (res_valid) begin
					state <= write;
					idx   <= '0;
				end
				write: if (wb_i.ack) begin
					idx <= idx + 1'b1;
					if (idx == IDX_W'(WORDS - 1))
						state <= finish;
				end
				finish: state <= idle;  // One cycle of done
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == idle && res_valid) begin
			m_q     <= res.m[BITS-1:0];
			r_adr_q <= res.r_adr;
		end
	end

	assign res_ready = (state == idle);
	assign done      = (state == finish);

endmodule

`default_nettype wire

// ==== verilog/wb_arbiter.sv ====
`default_nettype none

module wb_arbiter
	import wb_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  wb_m2s_t fetch_req,
	output wb_s2m_t fetch_rsp,
	input  wb_m2s_t store_req,
	output wb_s2m_t store_rsp,
	output wb_m2s_t wb_o,
	input  wb_s2m_t wb_i
);

	typedef enum logic [1:0] {own_none, own_fetch, own_store} owner_t;

	owner_t owner;
	logic   grant_fetch;
	logic   grant_store;

	// Current owner keeps the bus while its cyc is up, otherwise store first
	always_comb begin
		grant_fetch = 1'b0;
		grant_store = 1'b0;
		if (owner == own_fetch && fetch_req.cyc)
			grant_fetch = 1'b1;
		else if (owner == own_store && store_req.cyc)
			grant_store = 1'b1;
		else if (store_req.cyc)
			grant_store = 1'b1;
		else if (fetch_req.cyc)
			grant_fetch = 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			owner <= own_none;
		else
			owner <= grant_store ? own_store : (grant_fetch ? own_fetch : own_none);
	end

	always_comb begin
		wb_o = '0;  // Bus idle when nobody asks
		if (grant_store)
			wb_o = store_req;
		else if (grant_fetch)
			wb_o = fetch_req;
	end

	// Read data goes to both, ack only to the owner
	assign fetch_rsp = '{ack: wb_i.ack & grant_fetch, dat: wb_i.dat};
	assign store_rsp = '{ack: wb_i.ack & grant_store, dat: wb_i.dat};

endmodule

`default_nettype wire

// ==== verilog/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

	import mont_pkg::*;

	// Host command, all four are word aligned byte addresses
	typedef struct packed {
		addr_t a_adr;
		addr_t b_adr;
		addr_t n_adr;
		addr_t r_adr;
	} mont_cmd_t;

	// Wishbone classic, master to slave
	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		addr_t      adr;
		word_t      dat;
		logic [3:0] sel;
	} wb_m2s_t;

	// Wishbone classic, slave to master
	typedef struct packed {
		logic  ack;
		word_t dat;
	} wb_s2m_t;

endpackage

`default_nettype wire
